// ==== hw/rv_core_pkg.sv ====
// Shared widths, opcodes and instruction views for the small RV32I core
// Imported by every RTL file and by the testbench
`default_nettype none

package rv_core_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data and address width
  localparam int XLEN        = 32;
  // Register index width
  localparam int REG_ADDR_W  = 5;
  // Outstanding bus requests plus buffered responses
  localparam int FETCH_DEPTH = 2;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes accepted by execute
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 codes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 marking SUB, all other R-type ops use zero
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // R-type view
  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rv_rtype_t;

  // I-type view, upper 20 bits double as the U-type immediate
  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rv_itype_t;

  // One instruction word, decoded either way
  typedef union packed {
    rv_rtype_t r;
    rv_itype_t i;
  } rv_instr_u;

endpackage

`default_nettype wire

// ==== hw/rv_stage_ifs.sv ====
// Stage-to-stage interfaces inside the core
// fetch_ex_if carries a valid/ready handshake, ex_wb_if has no back-pressure
`timescale 1ns/1ns
`default_nettype none

interface fetch_ex_if;
  import rv_core_pkg::*;

  // Oldest buffered response
  logic            valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] pc;
  // Bus error on this word
  logic            err;
  // Execute accepts
  logic            ready;

  modport fetch (output valid, instr, pc, err, input ready);
  modport ex    (input valid, instr, pc, err, output ready);
endinterface

interface ex_wb_if;
  import rv_core_pkg::*;

  // Executed instruction, taken by writeback every cycle
  logic                  valid;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       result;
  logic [XLEN-1:0]       pc;

  // Writeback register fed back for operand bypass
  logic                  fwd_valid;
  logic [REG_ADDR_W-1:0] fwd_rd;
  logic [XLEN-1:0]       fwd_data;

  modport ex (output valid, rd, result, pc, input fwd_valid, fwd_rd, fwd_data);
  modport wb (input valid, rd, result, pc, output fwd_valid, fwd_rd, fwd_data);
endinterface

`default_nettype wire

// ==== hw/rv_fetch.sv ====
// Instruction fetch, OBI master with up to two requests in flight
// Responses land in a small in-order buffer that feeds execute
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fetch_enable_i,
  input  logic [rv_core_pkg::XLEN-1:0]  boot_addr_i,
  output logic                          instr_req_o,
  input  logic                          instr_gnt_i,
  output logic [rv_core_pkg::XLEN-1:0]  instr_addr_o,
  input  logic                          instr_rvalid_i,
  input  logic [rv_core_pkg::XLEN-1:0]  instr_rdata_i,
  input  logic                          instr_err_i,
  fetch_ex_if.fetch                     fetch_ex_o
);
  import rv_core_pkg::*;

  // Control state
  logic                                 running_q;
  logic                                 start;
  logic [XLEN-1:0]                      req_addr_q;
  logic [XLEN-1:0]                      rsp_pc_q;
  logic [$clog2(FETCH_DEPTH+1)-1:0]     out_cnt_q;
  logic [$clog2(FETCH_DEPTH+1)-1:0]     buf_cnt_q;
  logic [$clog2(FETCH_DEPTH)-1:0]       wr_ptr_q;
  logic [$clog2(FETCH_DEPTH)-1:0]       rd_ptr_q;
  logic                                 gnt_fire;
  logic                                 pop;

  // Response buffer payload
  logic [XLEN-1:0]                      buf_instr_q [FETCH_DEPTH];
  logic [XLEN-1:0]                      buf_pc_q    [FETCH_DEPTH];
  logic                                 buf_err_q   [FETCH_DEPTH];

  ////////////////////
  // Bus request
  ////////////////////

  // First enable edge starts the core
  assign start = fetch_enable_i && !running_q;

  // Only ask when a slot is guaranteed for the response
  assign instr_req_o  = running_q && ((out_cnt_q + buf_cnt_q) < FETCH_DEPTH);
  assign instr_addr_o = req_addr_q;
  assign gnt_fire     = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q  <= 1'b0;
      req_addr_q <= '0;
      rsp_pc_q   <= '0;
    end else begin
      if (start) begin
        running_q  <= 1'b1;
        req_addr_q <= boot_addr_i;
        rsp_pc_q   <= boot_addr_i;
      end else begin
        // Next word once this one is granted
        if (gnt_fire) req_addr_q <= req_addr_q + 32'd4;
        // Responses come back in order
        if (instr_rvalid_i) rsp_pc_q <= rsp_pc_q + 32'd4;
      end
    end
  end

  // Requests granted but not yet answered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_cnt_q <= '0;
    end else if (gnt_fire && !instr_rvalid_i) begin
      out_cnt_q <= out_cnt_q + 1'b1;
    end else if (!gnt_fire && instr_rvalid_i) begin
      out_cnt_q <= out_cnt_q - 1'b1;
    end
  end

  ////////////////////
  // Response buffer
  ////////////////////

  assign pop = fetch_ex_o.valid && fetch_ex_o.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_cnt_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end else begin
      if (instr_rvalid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (instr_rvalid_i && !pop) begin
        buf_cnt_q <= buf_cnt_q + 1'b1;
      end else if (!instr_rvalid_i && pop) begin
        buf_cnt_q <= buf_cnt_q - 1'b1;
      end
    end
  end

  // Payload, written at the tail
  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      buf_instr_q[wr_ptr_q] <= instr_rdata_i;
      buf_pc_q[wr_ptr_q]    <= rsp_pc_q;
      buf_err_q[wr_ptr_q]   <= instr_err_i;
    end
  end

  // Head entry goes to execute
  assign fetch_ex_o.valid = (buf_cnt_q != '0);
  assign fetch_ex_o.instr = buf_instr_q[rd_ptr_q];
  assign fetch_ex_o.pc    = buf_pc_q[rd_ptr_q];
  assign fetch_ex_o.err   = buf_err_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hw/rv_ex_stage.sv ====
// Decode and execute for the integer subset, one instruction per cycle
// Owns operand bypass from writeback and the sticky halt
`timescale 1ns/1ns
`default_nettype none

module rv_ex_stage (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  fetch_ex_if.ex                             fetch_ex_i,
  ex_wb_if.ex                                ex_wb_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [rv_core_pkg::XLEN-1:0]       rf_rdata_b_i,
  output logic                               halted_o,
  output logic [rv_core_pkg::XLEN-1:0]       halt_pc_o
);
  import rv_core_pkg::*;

  rv_instr_u       instr;
  logic            fire;
  logic            legal;
  logic            is_sub;
  logic            halt_q;
  logic [XLEN-1:0] halt_pc_q;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] alu_res;

  assign instr = fetch_ex_i.instr;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    case (instr.r.opcode)
      OPC_LUI:    legal = 1'b1;
      // SLTI is outside the subset
      OPC_OP_IMM: legal = instr.i.funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
      OPC_OP: begin
        legal = ((instr.r.funct7 == '0) &&
                 (instr.r.funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND, F3_SLT})) ||
                ((instr.r.funct7 == F7_SUB) && (instr.r.funct3 == F3_ADD));
      end
      default:    legal = 1'b0;
    endcase
  end

  // Sign-extended I immediate
  assign imm_i  = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  // LUI value from the top 20 bits of the I view
  assign imm_u  = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'h000};
  assign is_sub = (instr.r.opcode == OPC_OP) && (instr.r.funct7 == F7_SUB);

  ////////////////////
  // Operands
  ////////////////////

  assign rf_raddr_a_o = instr.r.rs1;
  assign rf_raddr_b_o = instr.r.rs2;

  // Writeback result is not in the register file yet
  always_comb begin
    rs1_val = rf_rdata_a_i;
    rs2_val = rf_rdata_b_i;
    if (ex_wb_o.fwd_valid && (ex_wb_o.fwd_rd == instr.r.rs1) && (instr.r.rs1 != '0)) begin
      rs1_val = ex_wb_o.fwd_data;
    end
    if (ex_wb_o.fwd_valid && (ex_wb_o.fwd_rd == instr.r.rs2) && (instr.r.rs2 != '0)) begin
      rs2_val = ex_wb_o.fwd_data;
    end
  end

  assign op_b = (instr.r.opcode == OPC_OP) ? rs2_val : imm_i;

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    case (instr.r.funct3)
      F3_ADD:  alu_res = is_sub ? (rs1_val - op_b) : (rs1_val + op_b);
      F3_XOR:  alu_res = rs1_val ^ op_b;
      F3_OR:   alu_res = rs1_val | op_b;
      F3_AND:  alu_res = rs1_val & op_b;
      F3_SLT:  alu_res = {{(XLEN-1){1'b0}}, ($signed(rs1_val) < $signed(op_b))};
      default: alu_res = rs1_val + op_b;
    endcase
    // LUI ignores funct3 bits, which belong to its immediate
    if (instr.r.opcode == OPC_LUI) alu_res = imm_u;
  end

  // Handshake, stalls for good once halted
  assign fetch_ex_i.ready = !halt_q;
  assign fire             = fetch_ex_i.valid && fetch_ex_i.ready;

  // Bad items never reach writeback
  assign ex_wb_o.valid  = fire && legal && !fetch_ex_i.err;
  assign ex_wb_o.rd     = instr.r.rd;
  assign ex_wb_o.result = alu_res;
  assign ex_wb_o.pc     = fetch_ex_i.pc;

  ////////////////////
  // Sticky halt
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      halt_q    <= 1'b0;
      halt_pc_q <= '0;
    end else if (fire && (fetch_ex_i.err || !legal)) begin
      halt_q    <= 1'b1;
      halt_pc_q <= fetch_ex_i.pc;
    end
  end

  assign halted_o  = halt_q;
  assign halt_pc_o = halt_pc_q;

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
// Integer register file, x1 to x31 in flops, x0 hardwired to zero
// Two combinational read ports, one write port
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [rv_core_pkg::XLEN-1:0]       rdata_b_o,
  input  logic                               we_i,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_core_pkg::XLEN-1:0]       wdata_i
);
  import rv_core_pkg::*;

  // No storage behind x0
  logic [XLEN-1:0] regs_q [1:(2**REG_ADDR_W)-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 2**REG_ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value during a write, bypass lives in execute
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== hw/rv_wb_stage.sv ====
// Writeback register, drives the register file write and the retire trace
// Accepts every cycle and feeds its contents back for bypass
`timescale 1ns/1ns
`default_nettype none

module rv_wb_stage (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  ex_wb_if.wb                                ex_wb_i,
  output logic                               rf_we_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_core_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                               retire_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]       retire_pc_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]       retire_wdata_o,
  output logic [rv_core_pkg::XLEN-1:0]       retire_count_o
);
  import rv_core_pkg::*;

  logic                  valid_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       result_q;
  logic [XLEN-1:0]       pc_q;
  logic [XLEN-1:0]       count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      count_q <= '0;
    end else begin
      valid_q <= ex_wb_i.valid;
      // Bumped when the retire cycle ends
      if (valid_q) count_q <= count_q + 1'b1;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    rd_q     <= ex_wb_i.rd;
    result_q <= ex_wb_i.result;
    pc_q     <= ex_wb_i.pc;
  end

  // Register file write at end of retire cycle
  assign rf_we_o    = valid_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = result_q;

  // Bypass to execute
  assign ex_wb_i.fwd_valid = valid_q;
  assign ex_wb_i.fwd_rd    = rd_q;
  assign ex_wb_i.fwd_data  = result_q;

  // Retire trace
  assign retire_valid_o = valid_q;
  assign retire_pc_o    = pc_q;
  assign retire_rd_o    = rd_q;
  assign retire_wdata_o = result_q;
  assign retire_count_o = count_q;

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
// Top level of the small RV32I core
// Instruction bus in, retire trace and halt status out
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               fetch_enable_i,
  input  logic [rv_core_pkg::XLEN-1:0]       boot_addr_i,
  // Instruction bus
  output logic                               instr_req_o,
  input  logic                               instr_gnt_i,
  output logic [rv_core_pkg::XLEN-1:0]       instr_addr_o,
  input  logic                               instr_rvalid_i,
  input  logic [rv_core_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic                               instr_err_i,
  // Retirement trace
  output logic                               retire_valid_o,
  output logic [rv_core_pkg::XLEN-1:0]       retire_pc_o,
  output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [rv_core_pkg::XLEN-1:0]       retire_wdata_o,
  output logic [rv_core_pkg::XLEN-1:0]       retire_count_o,
  // Halt status
  output logic                               halted_o,
  output logic [rv_core_pkg::XLEN-1:0]       halt_pc_o
);
  import rv_core_pkg::*;

  // Register file ports
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  // Stage links
  fetch_ex_if fetch_ex_bus ();
  ex_wb_if    ex_wb_bus ();

  ////////////////////
  // Stages
  ////////////////////

  rv_fetch fetch_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_err_i    ( instr_err_i    ),
    .fetch_ex_o     ( fetch_ex_bus   )
  );

  rv_ex_stage ex_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_ex_i     ( fetch_ex_bus   ),
    .ex_wb_o        ( ex_wb_bus      ),
    .rf_raddr_a_o   ( rf_raddr_a     ),
    .rf_raddr_b_o   ( rf_raddr_b     ),
    .rf_rdata_a_i   ( rf_rdata_a     ),
    .rf_rdata_b_i   ( rf_rdata_b     ),
    .halted_o       ( halted_o       ),
    .halt_pc_o      ( halt_pc_o      )
  );

  rv_regfile regfile_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .raddr_a_i      ( rf_raddr_a     ),
    .raddr_b_i      ( rf_raddr_b     ),
    .rdata_a_o      ( rf_rdata_a     ),
    .rdata_b_o      ( rf_rdata_b     ),
    .we_i           ( rf_we          ),
    .waddr_i        ( rf_waddr       ),
    .wdata_i        ( rf_wdata       )
  );

  rv_wb_stage wb_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .ex_wb_i        ( ex_wb_bus      ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_wdata_o ( retire_wdata_o ),
    .retire_count_o ( retire_count_o )
  );

endmodule

`default_nettype wire

// ==== dv/rv_core_sva.sv ====
// Bus and halt assertions, bound into the core top level
`timescale 1ns/1ns
`default_nettype none

module rv_core_sva (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         instr_req_o,
  input logic                         instr_gnt_i,
  input logic [rv_core_pkg::XLEN-1:0] instr_addr_o,
  input logic                         halted_o,
  input logic                         retire_valid_o
);

  // Request and address hold until granted
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_addr_o changed before grant");

  // Halt is sticky
  halt_sticky_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted_o |=> halted_o)
    else $error("halted_o fell");

  // Nothing retires after halting
  no_retire_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted_o |=> !retire_valid_o)
    else $error("retirement after halt");

endmodule

bind rv_core rv_core_sva sva_i (.*);

`default_nettype wire

// ==== dv/rv_core_tb.sv ====
// Directed testbench for the small RV32I core with bus and reference models
// Runs as top module rv_core_tb and prints one line per test and a summary
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int         PERIOD     = 40;
  localparam logic [31:0] SEED      = 32'hd5f6;
  // Words the model can hold per program
  localparam int         MEM_WORDS  = 64;
  // Watchdog budget from program words times a per-word bound plus per-test overhead
  localparam int         TOTAL_WORDS = 41;
  localparam int         NUM_TESTS   = 6;
  localparam int         WD_CYCLES   = TOTAL_WORDS * 24 + NUM_TESTS * 40;

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_enable;
  logic [XLEN-1:0]       boot_addr;
  logic                  instr_req_o;
  logic                  instr_gnt_i;
  logic [XLEN-1:0]       instr_addr_o;
  logic                  instr_rvalid_i;
  logic [XLEN-1:0]       instr_rdata_i;
  logic                  instr_err_i;
  logic                  retire_valid_o;
  logic [XLEN-1:0]       retire_pc_o;
  logic [REG_ADDR_W-1:0] retire_rd_o;
  logic [XLEN-1:0]       retire_wdata_o;
  logic [XLEN-1:0]       retire_count_o;
  logic                  halted_o;
  logic [XLEN-1:0]       halt_pc_o;

  // Program and bus model state
  logic [31:0]           prog_q[$];
  // Memory image with fill words past the program
  logic [31:0]           mem [MEM_WORDS];
  int                    cur_err_idx;
  bit                    rnd_mode;
  logic [31:0]           lfsr;
  int                    gnt_wait;
  logic [XLEN-1:0]       next_addr;
  logic [XLEN-1:0]       rsp_addr_q[$];
  int                    rsp_wait_q[$];

  // Expected retirements
  logic [XLEN-1:0]       exp_pc_q[$];
  logic [REG_ADDR_W-1:0] exp_rd_q[$];
  logic [XLEN-1:0]       exp_data_q[$];
  logic [XLEN-1:0]       exp_halt_pc;
  int                    exp_count;

  int                    error_count;
  int                    test_count;

  rv_core rv_core_i (
    .clk_i          ( clk            ),
    .rst_n_i        ( rst_n          ),
    .fetch_enable_i ( fetch_enable   ),
    .boot_addr_i    ( boot_addr      ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_err_i    ( instr_err_i    ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_wdata_o ( retire_wdata_o ),
    .retire_count_o ( retire_count_o ),
    .halted_o       ( halted_o       ),
    .halt_pc_o      ( halt_pc_o      )
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic int lfsr_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return int'(v);
  endfunction

  function automatic int draw_delay();
    return rnd_mode ? lfsr_bits(2) : 0;
  endfunction

  // Unloaded words decode as opcode 7f which is never legal
  function automatic logic [31:0] fill_word(logic [XLEN-1:0] addr);
    return {addr[24:0] ^ addr[31:7], 7'h7f};
  endfunction

  function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                        logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_reg(string name, logic [REG_ADDR_W-1:0] got,
                           logic [REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Copies the program into the memory image and fills the rest
  task automatic build_image();
    for (int k = 0; k < MEM_WORDS; k++) begin
      if (k < prog_q.size()) begin
        mem[k] = prog_q[k];
      end else begin
        mem[k] = fill_word(boot_addr + 32'(4 * k));
      end
    end
  endtask

  ////////////////////
  // Bus model
  ////////////////////

  // Grants and responses decided on the falling edge for the next rising edge
  always @(negedge clk) begin
    int          idx;
    logic [31:0] a;
    if (!rst_n) begin
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      instr_err_i    = 1'b0;
      instr_rdata_i  = '0;
      gnt_wait       = 0;
      next_addr      = boot_addr;
      rsp_addr_q.delete();
      rsp_wait_q.delete();
    end else begin
      instr_rvalid_i = 1'b0;
      instr_err_i    = 1'b0;
      instr_rdata_i  = '0;
      // Oldest response first and in order
      if (rsp_addr_q.size() > 0) begin
        if (rsp_wait_q[0] == 0) begin
          a   = rsp_addr_q.pop_front();
          void'(rsp_wait_q.pop_front());
          idx = int'((a - boot_addr) >> 2);
          instr_rvalid_i = 1'b1;
          if (a >= boot_addr && idx < MEM_WORDS) begin
            instr_rdata_i = mem[idx];
            instr_err_i   = (idx == cur_err_idx);
          end else begin
            instr_rdata_i = fill_word(a);
          end
        end else begin
          rsp_wait_q[0] = rsp_wait_q[0] - 1;
        end
      end
      instr_gnt_i = 1'b0;
      if (instr_req_o) begin
        if (gnt_wait == 0) begin
          instr_gnt_i = 1'b1;
          // Requests walk up from the boot address one word per grant
          check_word("instr_addr_o", instr_addr_o, next_addr);
          next_addr = next_addr + 32'd4;
          rsp_addr_q.push_back(instr_addr_o);
          rsp_wait_q.push_back(draw_delay());
          gnt_wait = draw_delay();
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
    end
  end

  ////////////////////
  // Reference model and monitor
  ////////////////////

  // Walks the program by the ISA rules until an illegal word or bus error
  task automatic run_reference();
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    int          i;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    exp_pc_q.delete();
    exp_rd_q.delete();
    exp_data_q.delete();
    i = 0;
    ok = 1'b1;
    while (ok && i < prog_q.size()) begin
      w   = prog_q[i];
      op  = w[6:0];
      f3  = w[14:12];
      f7  = w[31:25];
      a   = regs[w[19:15]];
      res = '0;
      ok  = (i != cur_err_idx);
      case (op)
        OPC_LUI: res = {w[31:12], 12'h000};
        OPC_OP_IMM: begin
          b = {{20{w[31]}}, w[31:20]};
          case (f3)
            F3_ADD:  res = a + b;
            F3_XOR:  res = a ^ b;
            F3_OR:   res = a | b;
            F3_AND:  res = a & b;
            default: ok = 1'b0;
          endcase
        end
        OPC_OP: begin
          b = regs[w[24:20]];
          if (f7 == F7_SUB && f3 == F3_ADD) res = a - b;
          else if (f7 != 7'h00) ok = 1'b0;
          else begin
            case (f3)
              F3_ADD:  res = a + b;
              F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
              F3_XOR:  res = a ^ b;
              F3_OR:   res = a | b;
              F3_AND:  res = a & b;
              default: ok = 1'b0;
            endcase
          end
        end
        default: ok = 1'b0;
      endcase
      if (ok) begin
        // x0 stays zero for later reads
        if (w[11:7] != 5'd0) regs[w[11:7]] = res;
        exp_pc_q.push_back(boot_addr + 32'(4 * i));
        exp_rd_q.push_back(w[11:7]);
        exp_data_q.push_back(res);
        i++;
      end
    end
    // Falling off the program lands on a fill word
    exp_count   = i;
    exp_halt_pc = boot_addr + 32'(4 * i);
  endtask

  always @(negedge clk) begin
    if (rst_n && retire_valid_o) begin
      if (exp_pc_q.size() == 0) begin
        $display("Unexpected retirement at pc %h", retire_pc_o);
        error_count++;
      end else begin
        check_word("retire_pc_o", retire_pc_o, exp_pc_q.pop_front());
        check_reg("retire_rd_o", retire_rd_o, exp_rd_q.pop_front());
        check_word("retire_wdata_o", retire_wdata_o, exp_data_q.pop_front());
      end
    end
  end

  ////////////////////
  // Programs
  ////////////////////

  task automatic load_lui_imm();
    prog_q.delete();
    prog_q.push_back(enc_lui(5'd1, 20'h12345));
    prog_q.push_back(enc_i(F3_ADD, 5'd2, 5'd1, 12'h678));
    prog_q.push_back(enc_i(F3_XOR, 5'd3, 5'd2, 12'hfff));
    prog_q.push_back(enc_i(F3_OR, 5'd4, 5'd0, 12'h0f0));
    prog_q.push_back(enc_i(F3_AND, 5'd5, 5'd3, 12'h7ff));
    prog_q.push_back(enc_i(F3_ADD, 5'd6, 5'd0, 12'hffb));
    prog_q.push_back(enc_lui(5'd7, 20'hfffff));
  endtask

  // Each word depends on the one before it
  task automatic load_forward();
    prog_q.delete();
    prog_q.push_back(enc_i(F3_ADD, 5'd1, 5'd0, 12'h005));
    prog_q.push_back(enc_i(F3_ADD, 5'd1, 5'd1, 12'h007));
    prog_q.push_back(enc_r(F7_SUB, F3_ADD, 5'd2, 5'd0, 5'd1));
    // SUB taking its rs2 from writeback
    prog_q.push_back(enc_r(F7_SUB, F3_ADD, 5'd3, 5'd1, 5'd2));
    prog_q.push_back(enc_r(7'h00, F3_SLT, 5'd4, 5'd2, 5'd3));
    // Signed compare where an unsigned one gives 1
    prog_q.push_back(enc_r(7'h00, F3_SLT, 5'd5, 5'd4, 5'd2));
    // Dropped write to x0 followed at once by x0 reads
    prog_q.push_back(enc_r(7'h00, F3_ADD, 5'd0, 5'd5, 5'd3));
    prog_q.push_back(enc_r(7'h00, F3_ADD, 5'd6, 5'd0, 5'd0));
    prog_q.push_back(enc_r(7'h00, F3_XOR, 5'd7, 5'd6, 5'd3));
    prog_q.push_back(enc_r(7'h00, F3_OR, 5'd8, 5'd1, 5'd7));
  endtask

  task automatic load_illegal();
    prog_q.delete();
    prog_q.push_back(enc_i(F3_ADD, 5'd1, 5'd0, 12'h001));
    prog_q.push_back(enc_i(F3_ADD, 5'd2, 5'd1, 12'h001));
    prog_q.push_back(32'h0000_0073);
    prog_q.push_back(enc_i(F3_ADD, 5'd3, 5'd2, 12'h001));
  endtask

  task automatic load_bus_err();
    prog_q.delete();
    prog_q.push_back(enc_i(F3_ADD, 5'd1, 5'd0, 12'h003));
    prog_q.push_back(enc_i(F3_ADD, 5'd2, 5'd1, 12'h004));
    prog_q.push_back(enc_i(F3_ADD, 5'd3, 5'd2, 12'h005));
  endtask

  ////////////////////
  // Test runner
  ////////////////////

  // Resets, checks idle outputs, runs to the halt and checks the totals
  task automatic run_test(string name, logic [XLEN-1:0] boot, bit rnd, int err_idx);
    int errs_before;
    errs_before  = error_count;
    fetch_enable = 1'b0;
    rst_n        = 1'b0;
    boot_addr    = boot;
    rnd_mode     = rnd;
    cur_err_idx  = err_idx;
    run_reference();
    build_image();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("retire_valid_o", retire_valid_o, 1'b0);
    check_bit("halted_o", halted_o, 1'b0);
    check_word("retire_count_o", retire_count_o, '0);
    fetch_enable = 1'b1;
    while (!halted_o) @(negedge clk);
    // Let any stray retirement show up
    repeat (4) @(negedge clk);
    if (exp_pc_q.size() != 0) begin
      $display("Core halted with %0d retirements still expected", exp_pc_q.size());
      error_count++;
    end
    check_word("retire_count_o", retire_count_o, 32'(exp_count));
    check_word("halt_pc_o", halt_pc_o, exp_halt_pc);
    test_count++;
    $display("test %s done, %0d errors", name, error_count - errs_before);
  endtask

  initial begin
    rst_n          = 1'b0;
    fetch_enable   = 1'b0;
    boot_addr      = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    lfsr           = SEED;
    rnd_mode       = 1'b0;
    cur_err_idx    = -1;
    gnt_wait       = 0;
    next_addr      = '0;
    error_count    = 0;
    test_count     = 0;

    load_lui_imm();
    run_test("lui_imm", 32'h0000_0100, 1'b0, -1);
    load_forward();
    run_test("forward", 32'h0000_0200, 1'b0, -1);
    load_lui_imm();
    run_test("lui_imm_rand", 32'h0000_0100, 1'b1, -1);
    load_forward();
    run_test("forward_rand", 32'h0000_0200, 1'b1, -1);
    load_illegal();
    run_test("illegal", 32'h0000_0300, 1'b0, -1);
    load_bus_err();
    run_test("bus_err", 32'h0000_0400, 1'b1, 1);

    $display("%0d tests, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
hw/rv_core_pkg.sv
hw/rv_stage_ifs.sv
hw/rv_fetch.sv
hw/rv_ex_stage.sv
hw/rv_regfile.sv
hw/rv_wb_stage.sv
hw/rv_core.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module rv_core_tb \
  -f rv_core.f \
  -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/rv_core_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^=== PASS ===$"; then
  exit 0
else
  exit 1
fi
